// ==== rtl/rv_arch_pkg.sv ====
`default_nettype none

package rv_arch_pkg;

    // architectural register file.
    localparam int REG_IDX_W = 5;

    // machine mode CSR space.
    localparam int CSR_ADDR_W = 12;

    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    typedef logic [CSR_ADDR_W-1:0] csr_addr_t;

    // machine status.
    localparam csr_addr_t CSR_MSTATUS = 12'h300;

    // trap vector base, read by ecall in ID.
    localparam csr_addr_t CSR_MTVEC = 12'h305;

    // exception pc, read by mret in ID.
    localparam csr_addr_t CSR_MEPC = 12'h341;

    // trap cause, written along with mepc on ecall.
    localparam csr_addr_t CSR_MCAUSE = 12'h342;

endpackage

`default_nettype wire

// ==== rtl/pipe_ctrl_pkg.sv ====
`default_nettype none

package pipe_ctrl_pkg;

    localparam int CD_CTRL_W  = 3;
    localparam int WB_CTRL_W  = 4;
    localparam int EXE_CTRL_W = 5;
    localparam int EXE_SRC_W  = 3;
    localparam int MEM_CTRL_W = 4;

    typedef logic [CD_CTRL_W-1:0]  cd_ctrl_t;
    typedef logic [WB_CTRL_W-1:0]  wb_ctrl_t;
    typedef logic [EXE_CTRL_W-1:0] exe_ctrl_t;
    typedef logic [EXE_SRC_W-1:0]  exe_src_t;
    typedef logic [MEM_CTRL_W-1:0] mem_ctrl_t;

    // instruction class seen by the detector in ID.
    localparam cd_ctrl_t CD_NONE    = 3'd0;
    localparam cd_ctrl_t CD_BRANCH  = 3'd1;
    localparam cd_ctrl_t CD_JALR    = 3'd2;
    localparam cd_ctrl_t CD_ECALL   = 3'd3;
    localparam cd_ctrl_t CD_MRET    = 3'd4;
    localparam cd_ctrl_t CD_FENCE_I = 3'd5;
    localparam cd_ctrl_t CD_EBREAK  = 3'd6;

    // write-back source.
    localparam wb_ctrl_t WB_NONE   = 4'd0;
    localparam wb_ctrl_t WB_EXE    = 4'd1;
    localparam wb_ctrl_t WB_MEM    = 4'd2;
    localparam wb_ctrl_t WB_IMM    = 4'd3;
    localparam wb_ctrl_t WB_SNPC   = 4'd4;
    localparam wb_ctrl_t WB_CSRRW  = 4'd5;
    localparam wb_ctrl_t WB_CSRRS  = 4'd6;
    localparam wb_ctrl_t WB_CSRRWI = 4'd7;
    localparam wb_ctrl_t WB_ECALL  = 4'd8;

    localparam exe_ctrl_t EXE_NOP = 5'd0;

    // operand sources of the EXE stage.
    localparam exe_src_t SRC_NOP         = 3'd0;
    localparam exe_src_t SRC_R_R         = 3'd1;
    localparam exe_src_t SRC_R_I         = 3'd2;
    localparam exe_src_t SRC_PC_I        = 3'd3;
    localparam exe_src_t SRC_R_CSR       = 3'd4;
    localparam exe_src_t SRC_NOTR_CSR    = 3'd5;
    localparam exe_src_t SRC_CSR_ZIMM    = 3'd6;
    localparam exe_src_t SRC_CSR_NOTZIMM = 3'd7;

    // memory ops, codes not listed are loads.
    localparam mem_ctrl_t MEM_NONE    = 4'd0;
    localparam mem_ctrl_t MEM_SB      = 4'd5;
    localparam mem_ctrl_t MEM_SH      = 4'd6;
    localparam mem_ctrl_t MEM_SW      = 4'd7;
    localparam mem_ctrl_t MEM_SD      = 4'd8;
    localparam mem_ctrl_t MEM_FENCE_I = 4'd12;

endpackage

`default_nettype wire

// ==== rtl/hazard_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface hazard_if;

    logic id_hazard;
    logic exe_hazard;
    logic mem_hazard;
    logic fence_wait;
    logic ebreak_id;

    modport src (
        output id_hazard, exe_hazard, mem_hazard, fence_wait, ebreak_id
    );

    modport dst (
        input id_hazard, exe_hazard, mem_hazard, fence_wait, ebreak_id
    );

endinterface

`default_nettype wire

// ==== rtl/stage_write_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module stage_write_decoder
    import pipe_ctrl_pkg::*;
(
    input  wire logic     valid,
    input  wire wb_ctrl_t wb_ctrl,
    output logic          rd_write,
    output logic          csr_write,
    output logic          ecall_write
);

    always_comb begin
        rd_write    = 1'b0;
        csr_write   = 1'b0;
        ecall_write = 1'b0;
        if (valid) begin
            case (wb_ctrl)
                WB_EXE, WB_MEM, WB_IMM, WB_SNPC: begin
                    rd_write = 1'b1;
                end
                // csr ops write both rd and the csr.
                WB_CSRRW, WB_CSRRS, WB_CSRRWI: begin
                    rd_write  = 1'b1;
                    csr_write = 1'b1;
                end
                WB_ECALL: begin
                    ecall_write = 1'b1;
                end
                default: begin
                    rd_write = 1'b0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/operand_use_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_use_decoder
    import pipe_ctrl_pkg::*;
(
    input  wire logic      id_valid,
    input  wire cd_ctrl_t  cd_ctrl,
    input  wire logic      exe_valid,
    input  wire exe_ctrl_t exe_ctrl,
    input  wire exe_src_t  exe_src,
    input  wire logic      mem_valid,
    input  wire mem_ctrl_t mem_ctrl,
    output logic           id_rs1_read,
    output logic           id_rs2_read,
    output logic           id_mtvec_read,
    output logic           id_mepc_read,
    output logic           exe_rs1_read,
    output logic           exe_rs2_read,
    output logic           exe_csr_read,
    output logic           mem_rs2_read
);

    logic exe_active;

    // branches resolve in ID, so their operands are needed there.
    always_comb begin
        id_rs1_read   = 1'b0;
        id_rs2_read   = 1'b0;
        id_mtvec_read = 1'b0;
        id_mepc_read  = 1'b0;
        if (id_valid) begin
            case (cd_ctrl)
                CD_BRANCH: begin
                    id_rs1_read = 1'b1;
                    id_rs2_read = 1'b1;
                end
                CD_JALR: begin
                    id_rs1_read = 1'b1;
                end
                CD_ECALL: begin
                    id_mtvec_read = 1'b1;
                end
                CD_MRET: begin
                    id_mepc_read = 1'b1;
                end
                default: begin
                    id_rs1_read = 1'b0;
                end
            endcase
        end
    end

    assign exe_active = exe_valid && (exe_ctrl != EXE_NOP);

    always_comb begin
        exe_rs1_read = 1'b0;
        exe_rs2_read = 1'b0;
        exe_csr_read = 1'b0;
        if (exe_active) begin
            case (exe_src)
                SRC_R_R: begin
                    exe_rs1_read = 1'b1;
                    exe_rs2_read = 1'b1;
                end
                SRC_R_I: begin
                    exe_rs1_read = 1'b1;
                end
                SRC_R_CSR, SRC_NOTR_CSR: begin
                    exe_rs1_read = 1'b1;
                    exe_csr_read = 1'b1;
                end
                SRC_CSR_ZIMM, SRC_CSR_NOTZIMM: begin
                    exe_csr_read = 1'b1;
                end
                default: begin
                    exe_rs1_read = 1'b0;
                end
            endcase
        end
    end

    // store data comes from rs2.
    assign mem_rs2_read = mem_valid && ((mem_ctrl == MEM_SB) || (mem_ctrl == MEM_SH) ||
                                        (mem_ctrl == MEM_SW) || (mem_ctrl == MEM_SD));

endmodule

`default_nettype wire

// ==== rtl/hazard_matcher.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_matcher
    import rv_arch_pkg::*;
    import pipe_ctrl_pkg::*;
(
    input  wire logic      id_valid,
    input  wire cd_ctrl_t  cd_ctrl,
    input  wire reg_idx_t  id_rs1,
    input  wire reg_idx_t  id_rs2,
    input  wire logic      id_rs1_read,
    input  wire logic      id_rs2_read,
    input  wire logic      id_mtvec_read,
    input  wire logic      id_mepc_read,
    input  wire logic      exe_valid,
    input  wire wb_ctrl_t  exe_wb_ctrl,
    input  wire reg_idx_t  exe_rd,
    input  wire csr_addr_t exe_csr,
    input  wire reg_idx_t  exe_rs1,
    input  wire reg_idx_t  exe_rs2,
    input  wire logic      exe_rs1_read,
    input  wire logic      exe_rs2_read,
    input  wire logic      exe_csr_read,
    input  wire logic      mem_valid,
    input  wire mem_ctrl_t mem_ctrl,
    input  wire wb_ctrl_t  mem_wb_ctrl,
    input  wire reg_idx_t  mem_rd,
    input  wire csr_addr_t mem_csr,
    input  wire reg_idx_t  mem_rs2,
    input  wire logic      mem_rs2_read,
    input  wire logic      wb_valid,
    input  wire wb_ctrl_t  wb_ctrl,
    input  wire reg_idx_t  wb_rd,
    input  wire csr_addr_t wb_csr,
    hazard_if.src          hz
);

    logic exe_rd_write, exe_csr_write, exe_ecall_write;
    logic mem_rd_write, mem_csr_write, mem_ecall_write;
    logic wb_rd_write, wb_csr_write, wb_ecall_write;
    logic id_gpr_hit;
    logic id_csr_hit;
    logic exe_gpr_hit;
    logic exe_csr_hit;
    logic exe_trap_csr;

    function automatic logic rd_hit(input logic read, input reg_idx_t rs,
                                    input logic write, input reg_idx_t rd);
        return read && write && (rs == rd);
    endfunction

    function automatic logic csr_hit(input logic read, input csr_addr_t addr,
                                     input logic write, input csr_addr_t csr);
        return read && write && (addr == csr);
    endfunction

    stage_write_decoder u_exe_wr (
        .valid      (exe_valid),
        .wb_ctrl    (exe_wb_ctrl),
        .rd_write   (exe_rd_write),
        .csr_write  (exe_csr_write),
        .ecall_write(exe_ecall_write)
    );

    stage_write_decoder u_mem_wr (
        .valid      (mem_valid),
        .wb_ctrl    (mem_wb_ctrl),
        .rd_write   (mem_rd_write),
        .csr_write  (mem_csr_write),
        .ecall_write(mem_ecall_write)
    );

    stage_write_decoder u_wb_wr (
        .valid      (wb_valid),
        .wb_ctrl    (wb_ctrl),
        .rd_write   (wb_rd_write),
        .csr_write  (wb_csr_write),
        .ecall_write(wb_ecall_write)
    );

    // ID checks against all three older stages.
    assign id_gpr_hit = rd_hit(id_rs1_read, id_rs1, exe_rd_write, exe_rd)
                     || rd_hit(id_rs1_read, id_rs1, mem_rd_write, mem_rd)
                     || rd_hit(id_rs1_read, id_rs1, wb_rd_write, wb_rd)
                     || rd_hit(id_rs2_read, id_rs2, exe_rd_write, exe_rd)
                     || rd_hit(id_rs2_read, id_rs2, mem_rd_write, mem_rd)
                     || rd_hit(id_rs2_read, id_rs2, wb_rd_write, wb_rd);

    // an ecall in flight rewrites mepc.
    assign id_csr_hit = csr_hit(id_mtvec_read, CSR_MTVEC, exe_csr_write, exe_csr)
                     || csr_hit(id_mtvec_read, CSR_MTVEC, mem_csr_write, mem_csr)
                     || csr_hit(id_mtvec_read, CSR_MTVEC, wb_csr_write, wb_csr)
                     || csr_hit(id_mepc_read, CSR_MEPC, exe_csr_write, exe_csr)
                     || csr_hit(id_mepc_read, CSR_MEPC, mem_csr_write, mem_csr)
                     || csr_hit(id_mepc_read, CSR_MEPC, wb_csr_write, wb_csr)
                     || (id_mepc_read && (exe_ecall_write || mem_ecall_write || wb_ecall_write));

    assign exe_gpr_hit = rd_hit(exe_rs1_read, exe_rs1, mem_rd_write, mem_rd)
                      || rd_hit(exe_rs1_read, exe_rs1, wb_rd_write, wb_rd)
                      || rd_hit(exe_rs2_read, exe_rs2, mem_rd_write, mem_rd)
                      || rd_hit(exe_rs2_read, exe_rs2, wb_rd_write, wb_rd);

    assign exe_trap_csr = (exe_csr == CSR_MEPC) || (exe_csr == CSR_MCAUSE);

    assign exe_csr_hit = csr_hit(exe_csr_read, exe_csr, mem_csr_write, mem_csr)
                      || csr_hit(exe_csr_read, exe_csr, wb_csr_write, wb_csr)
                      || (exe_csr_read && exe_trap_csr && (mem_ecall_write || wb_ecall_write));

    assign hz.id_hazard  = id_gpr_hit || id_csr_hit;
    assign hz.exe_hazard = exe_gpr_hit || exe_csr_hit;
    assign hz.mem_hazard = rd_hit(mem_rs2_read, mem_rs2, wb_rd_write, wb_rd);

    // fence.i holds fetch until it reaches MEM.
    assign hz.fence_wait = id_valid && (cd_ctrl == CD_FENCE_I) && (mem_ctrl != MEM_FENCE_I);
    assign hz.ebreak_id  = id_valid && (cd_ctrl == CD_EBREAK);

endmodule

`default_nettype wire

// ==== rtl/pipeline_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipeline_control (
    input  wire logic clk,
    input  wire logic rst_n,
    hazard_if.dst     hz,
    input  wire logic id_valid,
    input  wire logic if_ctrl,
    input  wire logic exe_valid,
    input  wire logic mem_valid,
    input  wire logic wb_valid,
    output logic      if_reg_valid,
    output logic      if_reg_enable,
    output logic      id_reg_valid,
    output logic      id_reg_enable,
    output logic      exe_reg_valid,
    output logic      exe_reg_enable,
    output logic      mem_reg_valid,
    output logic      mem_reg_enable,
    output logic      wb_reg_valid,
    output logic      halt
);

    logic any_hazard;
    logic pipe_empty;

    assign any_hazard = hz.id_hazard || hz.exe_hazard || hz.mem_hazard;

    // a stall in any stage freezes everything upstream of it.
    assign if_reg_valid   = !(hz.id_hazard || hz.fence_wait || hz.ebreak_id);
    assign if_reg_enable  = !any_hazard;
    assign id_reg_valid   = !(id_valid && if_ctrl);
    assign id_reg_enable  = !(any_hazard || hz.ebreak_id);
    assign exe_reg_valid  = !(hz.id_hazard || hz.ebreak_id);
    assign exe_reg_enable = !(hz.exe_hazard || hz.mem_hazard);
    assign mem_reg_valid  = !hz.exe_hazard;
    assign mem_reg_enable = !hz.mem_hazard;
    assign wb_reg_valid   = !hz.mem_hazard;

    // ebreak only halts once older instructions have retired.
    assign pipe_empty = !exe_valid && !mem_valid && !wb_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            halt <= 1'b0;
        end else if (hz.ebreak_id && pipe_empty) begin
            halt <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/hazard_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_unit
    import rv_arch_pkg::*;
    import pipe_ctrl_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire cd_ctrl_t  cd_ctrl,
    input  wire logic      if_ctrl,
    input  wire logic      id_valid,
    input  wire reg_idx_t  id_rs1,
    input  wire reg_idx_t  id_rs2,
    input  wire logic      exe_valid,
    input  wire exe_ctrl_t exe_ctrl,
    input  wire exe_src_t  exe_src,
    input  wire wb_ctrl_t  exe_wb_ctrl,
    input  wire reg_idx_t  exe_rd,
    input  wire reg_idx_t  exe_rs1,
    input  wire reg_idx_t  exe_rs2,
    input  wire csr_addr_t exe_csr,
    input  wire logic      mem_valid,
    input  wire mem_ctrl_t mem_ctrl,
    input  wire wb_ctrl_t  mem_wb_ctrl,
    input  wire reg_idx_t  mem_rd,
    input  wire reg_idx_t  mem_rs2,
    input  wire csr_addr_t mem_csr,
    input  wire logic      wb_valid,
    input  wire wb_ctrl_t  wb_ctrl,
    input  wire reg_idx_t  wb_rd,
    input  wire csr_addr_t wb_csr,
    output logic           if_reg_valid,
    output logic           if_reg_enable,
    output logic           id_reg_valid,
    output logic           id_reg_enable,
    output logic           exe_reg_valid,
    output logic           exe_reg_enable,
    output logic           mem_reg_valid,
    output logic           mem_reg_enable,
    output logic           wb_reg_valid,
    output logic           halt
);

    logic id_rs1_read;
    logic id_rs2_read;
    logic id_mtvec_read;
    logic id_mepc_read;
    logic exe_rs1_read;
    logic exe_rs2_read;
    logic exe_csr_read;
    logic mem_rs2_read;

    hazard_if hz_if ();

    operand_use_decoder u_use (
        .id_valid     (id_valid),
        .cd_ctrl      (cd_ctrl),
        .exe_valid    (exe_valid),
        .exe_ctrl     (exe_ctrl),
        .exe_src      (exe_src),
        .mem_valid    (mem_valid),
        .mem_ctrl     (mem_ctrl),
        .id_rs1_read  (id_rs1_read),
        .id_rs2_read  (id_rs2_read),
        .id_mtvec_read(id_mtvec_read),
        .id_mepc_read (id_mepc_read),
        .exe_rs1_read (exe_rs1_read),
        .exe_rs2_read (exe_rs2_read),
        .exe_csr_read (exe_csr_read),
        .mem_rs2_read (mem_rs2_read)
    );

    hazard_matcher u_match (
        .id_valid     (id_valid),
        .cd_ctrl      (cd_ctrl),
        .id_rs1       (id_rs1),
        .id_rs2       (id_rs2),
        .id_rs1_read  (id_rs1_read),
        .id_rs2_read  (id_rs2_read),
        .id_mtvec_read(id_mtvec_read),
        .id_mepc_read (id_mepc_read),
        .exe_valid    (exe_valid),
        .exe_wb_ctrl  (exe_wb_ctrl),
        .exe_rd       (exe_rd),
        .exe_csr      (exe_csr),
        .exe_rs1      (exe_rs1),
        .exe_rs2      (exe_rs2),
        .exe_rs1_read (exe_rs1_read),
        .exe_rs2_read (exe_rs2_read),
        .exe_csr_read (exe_csr_read),
        .mem_valid    (mem_valid),
        .mem_ctrl     (mem_ctrl),
        .mem_wb_ctrl  (mem_wb_ctrl),
        .mem_rd       (mem_rd),
        .mem_csr      (mem_csr),
        .mem_rs2      (mem_rs2),
        .mem_rs2_read (mem_rs2_read),
        .wb_valid     (wb_valid),
        .wb_ctrl      (wb_ctrl),
        .wb_rd        (wb_rd),
        .wb_csr       (wb_csr),
        .hz           (hz_if.src)
    );

    pipeline_control u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .hz            (hz_if.dst),
        .id_valid      (id_valid),
        .if_ctrl       (if_ctrl),
        .exe_valid     (exe_valid),
        .mem_valid     (mem_valid),
        .wb_valid      (wb_valid),
        .if_reg_valid  (if_reg_valid),
        .if_reg_enable (if_reg_enable),
        .id_reg_valid  (id_reg_valid),
        .id_reg_enable (id_reg_enable),
        .exe_reg_valid (exe_reg_valid),
        .exe_reg_enable(exe_reg_enable),
        .mem_reg_valid (mem_reg_valid),
        .mem_reg_enable(mem_reg_enable),
        .wb_reg_valid  (wb_reg_valid),
        .halt          (halt)
    );

endmodule

`default_nettype wire

// ==== test/hazard_unit_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_unit_checker (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic mem_hazard,
    input wire logic halt,
    input wire logic if_reg_enable,
    input wire logic id_reg_enable,
    input wire logic exe_reg_enable,
    input wire logic mem_reg_enable,
    input wire logic wb_reg_valid
);

    int violations = 0;

    // halt only clears through reset.
    halt_sticky: assert property (@(posedge clk) disable iff (!rst_n) halt |=> halt)
        else begin
            violations++;
            $error("halt fell while rst_n was high");
        end

    mem_stall_pair: assert property (@(posedge clk) disable iff (!rst_n)
        mem_hazard |-> (!wb_reg_valid && !mem_reg_enable))
        else begin
            violations++;
            $error("mem hazard without both wb_reg_valid and mem_reg_enable low");
        end

    // a MEM stall freezes every stage upstream.
    mem_stall_freeze: assert property (@(posedge clk) disable iff (!rst_n)
        mem_hazard |-> !(if_reg_enable || id_reg_enable || exe_reg_enable || mem_reg_enable))
        else begin
            violations++;
            $error("mem hazard with a register enable still high");
        end

endmodule

bind pipeline_control hazard_unit_checker chk0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .mem_hazard    (hz.mem_hazard),
    .halt          (halt),
    .if_reg_enable (if_reg_enable),
    .id_reg_enable (id_reg_enable),
    .exe_reg_enable(exe_reg_enable),
    .mem_reg_enable(mem_reg_enable),
    .wb_reg_valid  (wb_reg_valid)
);

`default_nettype wire

// ==== test/hazard_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_unit_tb
    import rv_arch_pkg::*;
    import pipe_ctrl_pkg::*;
();

    // if_v, if_en, id_v, id_en, exe_v, exe_en, mem_v, mem_en, wb_v.
    typedef logic [8:0] ctrl_vec_t;

    typedef struct {
        string     name;
        cd_ctrl_t  cd_ctrl;
        logic      if_ctrl;
        logic      id_valid;
        reg_idx_t  id_rs1;
        reg_idx_t  id_rs2;
        logic      exe_valid;
        exe_ctrl_t exe_ctrl;
        exe_src_t  exe_src;
        wb_ctrl_t  exe_wb_ctrl;
        reg_idx_t  exe_rd;
        reg_idx_t  exe_rs1;
        reg_idx_t  exe_rs2;
        csr_addr_t exe_csr;
        logic      mem_valid;
        mem_ctrl_t mem_ctrl;
        wb_ctrl_t  mem_wb_ctrl;
        reg_idx_t  mem_rd;
        reg_idx_t  mem_rs2;
        csr_addr_t mem_csr;
        logic      wb_valid;
        wb_ctrl_t  wb_ctrl;
        reg_idx_t  wb_rd;
        csr_addr_t wb_csr;
        ctrl_vec_t exp_ctrl;
        logic      exp_halt;
    } entry_t;

    logic      clk;
    logic      rst_n;
    cd_ctrl_t  cd_ctrl;
    logic      if_ctrl;
    logic      id_valid;
    reg_idx_t  id_rs1;
    reg_idx_t  id_rs2;
    logic      exe_valid;
    exe_ctrl_t exe_ctrl;
    exe_src_t  exe_src;
    wb_ctrl_t  exe_wb_ctrl;
    reg_idx_t  exe_rd;
    reg_idx_t  exe_rs1;
    reg_idx_t  exe_rs2;
    csr_addr_t exe_csr;
    logic      mem_valid;
    mem_ctrl_t mem_ctrl;
    wb_ctrl_t  mem_wb_ctrl;
    reg_idx_t  mem_rd;
    reg_idx_t  mem_rs2;
    csr_addr_t mem_csr;
    logic      wb_valid;
    wb_ctrl_t  wb_ctrl;
    reg_idx_t  wb_rd;
    csr_addr_t wb_csr;
    logic      if_reg_valid;
    logic      if_reg_enable;
    logic      id_reg_valid;
    logic      id_reg_enable;
    logic      exe_reg_valid;
    logic      exe_reg_enable;
    logic      mem_reg_valid;
    logic      mem_reg_enable;
    logic      wb_reg_valid;
    logic      halt;
    ctrl_vec_t ctrl_act;

    entry_t      entries[$];
    logic [31:0] rng;
    int          error_count = 0;
    int          pass_count = 0;
    int          fail_count = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    hazard_unit dut0 (.*);

    assign ctrl_act = {if_reg_valid, if_reg_enable, id_reg_valid, id_reg_enable, exe_reg_valid,
                       exe_reg_enable, mem_reg_valid, mem_reg_enable, wb_reg_valid};

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic csr_addr_t csr_pick(input logic [1:0] sel);
        case (sel)
            2'd0:    return CSR_MSTATUS;
            2'd1:    return CSR_MTVEC;
            2'd2:    return CSR_MEPC;
            default: return CSR_MCAUSE;
        endcase
    endfunction

    // independent instructions in every stage.
    function automatic entry_t base_entry(input string name);
        entry_t e;
        e.name        = name;
        e.cd_ctrl     = CD_BRANCH;
        e.if_ctrl     = 1'b0;
        e.id_valid    = 1'b1;
        e.id_rs1      = 5'd1;
        e.id_rs2      = 5'd2;
        e.exe_valid   = 1'b1;
        e.exe_ctrl    = 5'd1;
        e.exe_src     = SRC_R_R;
        e.exe_wb_ctrl = WB_EXE;
        e.exe_rd      = 5'd3;
        e.exe_rs1     = 5'd4;
        e.exe_rs2     = 5'd5;
        e.exe_csr     = CSR_MSTATUS;
        e.mem_valid   = 1'b1;
        e.mem_ctrl    = MEM_NONE;
        e.mem_wb_ctrl = WB_EXE;
        e.mem_rd      = 5'd6;
        e.mem_rs2     = 5'd7;
        e.mem_csr     = 12'h000;
        e.wb_valid    = 1'b1;
        e.wb_ctrl     = WB_EXE;
        e.wb_rd       = 5'd9;
        e.wb_csr      = 12'h000;
        e.exp_ctrl    = 9'h1ff;
        e.exp_halt    = 1'b0;
        return e;
    endfunction

    function automatic entry_t random_entry(input int k, input logic [31:0] r0,
                                            input logic [31:0] r1);
        entry_t e;
        e = base_entry($sformatf("random_%0d", k));
        e.cd_ctrl     = cd_ctrl_t'(r0[2:0]);
        e.if_ctrl     = r0[3];
        e.id_valid    = r0[4] | r0[5];
        e.id_rs1      = reg_idx_t'(r0[7:6]);
        e.id_rs2      = reg_idx_t'(r0[9:8]);
        e.exe_valid   = r0[10] | r0[11];
        e.exe_ctrl    = exe_ctrl_t'(r0[12] | r0[28]);
        e.exe_src     = exe_src_t'(r0[15:13]);
        e.exe_wb_ctrl = wb_ctrl_t'(r0[19:16] % 4'd9);
        e.exe_rd      = reg_idx_t'(r0[21:20]);
        e.exe_rs1     = reg_idx_t'(r0[23:22]);
        e.exe_rs2     = reg_idx_t'(r0[25:24]);
        e.exe_csr     = csr_pick(r0[27:26]);
        e.mem_valid   = r1[0] | r1[1];
        e.mem_ctrl    = mem_ctrl_t'(r1[5:2]);
        e.mem_wb_ctrl = wb_ctrl_t'(r1[9:6] % 4'd9);
        e.mem_rd      = reg_idx_t'(r1[11:10]);
        e.mem_rs2     = reg_idx_t'(r1[13:12]);
        e.mem_csr     = csr_pick(r1[15:14]);
        e.wb_valid    = r1[16] | r1[17];
        e.wb_ctrl     = wb_ctrl_t'(r1[21:18] % 4'd9);
        e.wb_rd       = reg_idx_t'(r1[23:22]);
        e.wb_csr      = csr_pick(r1[25:24]);
        return e;
    endfunction

    // reference model of the detector rules.
    function automatic ctrl_vec_t expected_ctrl(input entry_t t);
        logic ew, mw, ww, ecw, mcw, wcw, eec, mec, wec;
        logic r1, r2, rtvec, repc, act, er1, er2, ecr, store;
        logic id_hz, exe_hz, mem_hz, fence, eb, any;
        ew    = t.exe_valid && (t.exe_wb_ctrl >= 4'd1) && (t.exe_wb_ctrl <= 4'd7);
        mw    = t.mem_valid && (t.mem_wb_ctrl >= 4'd1) && (t.mem_wb_ctrl <= 4'd7);
        ww    = t.wb_valid && (t.wb_ctrl >= 4'd1) && (t.wb_ctrl <= 4'd7);
        ecw   = t.exe_valid && (t.exe_wb_ctrl >= 4'd5) && (t.exe_wb_ctrl <= 4'd7);
        mcw   = t.mem_valid && (t.mem_wb_ctrl >= 4'd5) && (t.mem_wb_ctrl <= 4'd7);
        wcw   = t.wb_valid && (t.wb_ctrl >= 4'd5) && (t.wb_ctrl <= 4'd7);
        eec   = t.exe_valid && (t.exe_wb_ctrl == 4'd8);
        mec   = t.mem_valid && (t.mem_wb_ctrl == 4'd8);
        wec   = t.wb_valid && (t.wb_ctrl == 4'd8);
        r1    = t.id_valid && ((t.cd_ctrl == 3'd1) || (t.cd_ctrl == 3'd2));
        r2    = t.id_valid && (t.cd_ctrl == 3'd1);
        rtvec = t.id_valid && (t.cd_ctrl == 3'd3);
        repc  = t.id_valid && (t.cd_ctrl == 3'd4);
        act   = t.exe_valid && (t.exe_ctrl != 5'd0);
        er1   = act && (t.exe_src inside {3'd1, 3'd2, 3'd4, 3'd5});
        er2   = act && (t.exe_src == 3'd1);
        ecr   = act && (t.exe_src >= 3'd4);
        store = t.mem_valid && (t.mem_ctrl >= 4'd5) && (t.mem_ctrl <= 4'd8);
        id_hz = (r1 && ((ew && t.id_rs1 == t.exe_rd) || (mw && t.id_rs1 == t.mem_rd) ||
                        (ww && t.id_rs1 == t.wb_rd)))
             || (r2 && ((ew && t.id_rs2 == t.exe_rd) || (mw && t.id_rs2 == t.mem_rd) ||
                        (ww && t.id_rs2 == t.wb_rd)))
             || (rtvec && ((ecw && t.exe_csr == 12'h305) || (mcw && t.mem_csr == 12'h305) ||
                           (wcw && t.wb_csr == 12'h305)))
             || (repc && ((ecw && t.exe_csr == 12'h341) || (mcw && t.mem_csr == 12'h341) ||
                          (wcw && t.wb_csr == 12'h341) || eec || mec || wec));
        exe_hz = (er1 && ((mw && t.exe_rs1 == t.mem_rd) || (ww && t.exe_rs1 == t.wb_rd)))
              || (er2 && ((mw && t.exe_rs2 == t.mem_rd) || (ww && t.exe_rs2 == t.wb_rd)))
              || (ecr && ((mcw && t.exe_csr == t.mem_csr) || (wcw && t.exe_csr == t.wb_csr)))
              || (ecr && (t.exe_csr == 12'h341 || t.exe_csr == 12'h342) && (mec || wec));
        mem_hz = store && ww && (t.mem_rs2 == t.wb_rd);
        fence  = t.id_valid && (t.cd_ctrl == 3'd5) && (t.mem_ctrl != 4'd12);
        eb     = t.id_valid && (t.cd_ctrl == 3'd6);
        any    = id_hz || exe_hz || mem_hz;
        return {!(id_hz || fence || eb), !any, !(t.id_valid && t.if_ctrl), !(any || eb),
                !(id_hz || eb), !(exe_hz || mem_hz), !exe_hz, !mem_hz, !mem_hz};
    endfunction

    task automatic drive_entry(input entry_t e);
        cd_ctrl     = e.cd_ctrl;
        if_ctrl     = e.if_ctrl;
        id_valid    = e.id_valid;
        id_rs1      = e.id_rs1;
        id_rs2      = e.id_rs2;
        exe_valid   = e.exe_valid;
        exe_ctrl    = e.exe_ctrl;
        exe_src     = e.exe_src;
        exe_wb_ctrl = e.exe_wb_ctrl;
        exe_rd      = e.exe_rd;
        exe_rs1     = e.exe_rs1;
        exe_rs2     = e.exe_rs2;
        exe_csr     = e.exe_csr;
        mem_valid   = e.mem_valid;
        mem_ctrl    = e.mem_ctrl;
        mem_wb_ctrl = e.mem_wb_ctrl;
        mem_rd      = e.mem_rd;
        mem_rs2     = e.mem_rs2;
        mem_csr     = e.mem_csr;
        wb_valid    = e.wb_valid;
        wb_ctrl     = e.wb_ctrl;
        wb_rd       = e.wb_rd;
        wb_csr      = e.wb_csr;
    endtask

    task automatic add_entry(input entry_t e, input ctrl_vec_t exp_ctrl, input logic exp_halt);
        e.exp_ctrl = exp_ctrl;
        e.exp_halt = exp_halt;
        entries.push_back(e);
    endtask

    task automatic check_ctrl(input string name, input ctrl_vec_t exp, input ctrl_vec_t act);
        if (act !== exp) begin
            error_count++;
            $display("mismatch %s controls: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_halt(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            error_count++;
            $display("mismatch %s halt: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (error_count == errs_before) begin
            pass_count++;
            $display("pass %s", name);
        end else begin
            fail_count++;
            $display("fail %s", name);
        end
    endtask

    initial begin
        entry_t      e;
        logic        halt_run;
        logic [31:0] r0;
        logic [31:0] r1;
        int          errs_before;
        int          violations;
        clk   = 1'b0;
        rst_n = 1'b0;
        rng   = 32'h0abe_c7ce;
        drive_entry(base_entry("idle"));

        add_entry(base_entry("baseline"), 9'b111111111, 1'b0);
        e = base_entry("id_rs1_exe_raw");
        e.id_rs1  = 5'd3;
        e.if_ctrl = 1'b1;
        add_entry(e, 9'b000001111, 1'b0);
        e = base_entry("exe_rs2_mem_raw");
        e.exe_rs2 = 5'd6;
        add_entry(e, 9'b101010011, 1'b0);
        e = base_entry("mem_store_wb_raw");
        e.mem_ctrl = MEM_SW;
        e.mem_rs2  = 5'd9;
        add_entry(e, 9'b101010100, 1'b0);
        e.name     = "store_wb_invalid";
        e.wb_valid = 1'b0;
        add_entry(e, 9'b111111111, 1'b0);
        e = base_entry("mret_wb_ecall");
        e.cd_ctrl = CD_MRET;
        e.wb_ctrl = WB_ECALL;
        add_entry(e, 9'b001001111, 1'b0);
        e = base_entry("exe_mcause_mem_ecall");
        e.exe_src     = SRC_CSR_ZIMM;
        e.exe_csr     = CSR_MCAUSE;
        e.mem_wb_ctrl = WB_ECALL;
        add_entry(e, 9'b101010011, 1'b0);
        e.name    = "exe_mstatus_mem_ecall";
        e.exe_csr = CSR_MSTATUS;
        add_entry(e, 9'b111111111, 1'b0);
        e = base_entry("exe_csr_wb_csrrw");
        e.exe_src = SRC_CSR_ZIMM;
        e.exe_csr = CSR_MTVEC;
        e.wb_ctrl = WB_CSRRW;
        e.wb_csr  = CSR_MTVEC;
        add_entry(e, 9'b101010011, 1'b0);
        e = base_entry("branch_flush");
        e.if_ctrl = 1'b1;
        add_entry(e, 9'b110111111, 1'b0);
        e.name     = "flush_id_invalid";
        e.id_valid = 1'b0;
        add_entry(e, 9'b111111111, 1'b0);
        e = base_entry("fence_i_wait");
        e.cd_ctrl = CD_FENCE_I;
        add_entry(e, 9'b011111111, 1'b0);
        e.name     = "fence_i_in_mem";
        e.mem_ctrl = MEM_FENCE_I;
        add_entry(e, 9'b111111111, 1'b0);
        e = base_entry("ebreak_busy");
        e.cd_ctrl = CD_EBREAK;
        add_entry(e, 9'b011001111, 1'b0);
        e.name      = "ebreak_empty";
        e.exe_valid = 1'b0;
        e.mem_valid = 1'b0;
        e.wb_valid  = 1'b0;
        add_entry(e, 9'b011001111, 1'b1);
        add_entry(base_entry("halt_sticky"), 9'b111111111, 1'b1);

        halt_run = entries[entries.size() - 1].exp_halt;
        for (int k = 0; k < 16; k++) begin
            rng = xorshift(rng);
            r0  = rng;
            rng = xorshift(rng);
            r1  = rng;
            e   = random_entry(k, r0, r1);
            e.exp_ctrl = expected_ctrl(e);
            halt_run   = halt_run || (e.id_valid && (e.cd_ctrl == CD_EBREAK) &&
                                      !e.exe_valid && !e.mem_valid && !e.wb_valid);
            e.exp_halt = halt_run;
            entries.push_back(e);
        end
        cycle_limit = entries.size() * 3 + 20;

        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        foreach (entries[i]) begin
            errs_before = error_count;
            drive_entry(entries[i]);
            #6;
            check_ctrl(entries[i].name, entries[i].exp_ctrl, ctrl_act);
            @(posedge clk);
            #1;
            check_halt(entries[i].name, entries[i].exp_halt, halt);
            finish_test(entries[i].name, errs_before);
        end

        errs_before = error_count;
        rst_n = 1'b0;
        #2;
        check_halt("reset_clears_halt", 1'b0, halt);
        finish_test("reset_clears_halt", errs_before);

        violations = dut0.u_ctrl.chk0.violations;
        if (violations != 0) begin
            $display("assertion checker flagged %0d violations", violations);
        end
        $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
        if (fail_count == 0 && violations == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
rtl/rv_arch_pkg.sv
rtl/pipe_ctrl_pkg.sv
rtl/hazard_if.sv
rtl/stage_write_decoder.sv
rtl/operand_use_decoder.sv
rtl/hazard_matcher.sv
rtl/pipeline_control.sv
rtl/hazard_unit.sv
test/hazard_unit_checker.sv
test/hazard_unit_tb.sv
